// File: design/chdr_deframer_pkg.sv
// Shared definitions for the CHDR data packet deframer
// Holds the 64-bit CHDR header field positions, packet type codes,
// bus widths and the packed beat/sideband structs used on every link.
// Other files refer to these through chdr_deframer_pkg:: scoped names
package chdr_deframer_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int chdr_w = 64;
  localparam int item_w = 32;
  // Items per output payload beat
  localparam int nipc   = 2;

  // Data packet type codes
  localparam logic [2:0] pkt_type_data    = 3'd6;
  localparam logic [2:0] pkt_type_data_ts = 3'd7;

  // --------------------
  // Header bit positions
  // --------------------
  localparam int hdr_eob_bit       = 57;
  localparam int hdr_eov_bit       = 56;
  localparam int hdr_pkt_type_msb  = 55;
  localparam int hdr_pkt_type_lsb  = 53;
  localparam int hdr_num_mdata_msb = 52;
  localparam int hdr_num_mdata_lsb = 48;
  // Total packet bytes, header word included
  localparam int hdr_length_msb    = 31;
  localparam int hdr_length_lsb    = 16;

  // Default entries per stream FIFO
  localparam int fifo_depth_default = 4;

  // --------------------
  // Beat and sideband types
  // --------------------
  // One CHDR input word
  typedef struct packed {
    logic [chdr_w-1:0] data;
    logic              last;
  } chdr_beat_t;

  // Payload beat, item 0 in the low half, keep bit per item
  typedef struct packed {
    logic [item_w*nipc-1:0] data;
    logic [nipc-1:0]        keep;
    logic                   last;
  } pyld_beat_t;

  // Metadata beat, keep low marks the empty beat of a packet without metadata
  typedef struct packed {
    logic [chdr_w-1:0] data;
    logic              keep;
    logic              last;
  } mdata_beat_t;

  // Per-packet sideband, length counts payload bytes only
  typedef struct packed {
    logic [63:0] timestamp;
    logic        has_time;
    logic [15:0] length;
    logic        eob;
    logic        eov;
  } pkt_info_t;

endpackage

// File: design/chdr_stream_fifo.sv
`timescale 1ns/1ps
// Synchronous valid/ready FIFO for any packed payload type
// Circular buffer behind a registered output stage, one cycle from write to read.
// Holds depth entries in the buffer plus one in the output register
module chdr_stream_fifo #(
  parameter type payload_t = logic [63:0],
  parameter int  depth     = chdr_deframer_pkg::fifo_depth_default
) (
  input  logic     axis_chdr_clk,
  input  logic     axis_chdr_rst,
  // Write side
  input  payload_t i_data,
  input  logic     i_valid,
  output logic     o_ready,
  // Read side
  output payload_t o_data,
  output logic     o_valid,
  input  logic     i_ready
);
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_en;
  logic             out_free;
  logic             mem_empty;
  logic             mem_wr;
  logic             mem_rd;

  assign wr_en     = i_valid && o_ready;
  // Output register can take a new beat
  assign out_free  = !o_valid || i_ready;
  assign mem_empty = (count == '0);
  // Bypass the buffer when it is empty and the output stage is free
  assign mem_wr    = wr_en && !(mem_empty && out_free);
  assign mem_rd    = out_free && !mem_empty;
  assign o_ready   = (count < cnt_w'(depth));

  // Buffer storage
  always_ff @(posedge axis_chdr_clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers, fill count and output valid
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({mem_wr, mem_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (out_free) begin
        o_valid <= !mem_empty || wr_en;
      end
    end
  end

  // Oldest buffered entry first, else straight from the write side
  always_ff @(posedge axis_chdr_clk) begin
    if (out_free) begin
      o_data <= mem_empty ? i_data : mem[rd_ptr];
    end
  end

  // No write while full, a write never lands on an entry still unread
  a_no_overflow : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    (mem_wr && !mem_empty) |-> (wr_ptr != rd_ptr));
  // No read while empty, so the pointers meet whenever the count is zero
  a_no_underflow : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    mem_empty |-> (wr_ptr == rd_ptr));

endmodule

// File: design/chdr_header_parser.sv
`timescale 1ns/1ps
// Input FSM of the CHDR deframer
// Splits each 64-bit CHDR data packet into a sideband info beat, a metadata
// packet and a payload packet. Non-data packets are consumed and dropped.
// Fully combinational from input to the FIFO write sides
module chdr_header_parser (
  input  logic                             axis_chdr_clk,
  input  logic                             axis_chdr_rst,
  // CHDR input
  input  chdr_deframer_pkg::chdr_beat_t    i_chdr,
  input  logic                             i_chdr_valid,
  output logic                             o_chdr_ready,
  // Packet info out
  output chdr_deframer_pkg::pkt_info_t     o_info,
  output logic                             o_info_valid,
  input  logic                             i_info_ready,
  // Metadata out
  output chdr_deframer_pkg::mdata_beat_t   o_mdata,
  output logic                             o_mdata_valid,
  input  logic                             i_mdata_ready,
  // Payload out
  output chdr_deframer_pkg::pyld_beat_t    o_pyld,
  output logic                             o_pyld_valid,
  input  logic                             i_pyld_ready
);
  typedef enum logic [2:0] {
    st_header    = 3'd0,
    st_timestamp = 3'd1,
    st_mdata     = 3'd2,
    st_body      = 3'd3,
    st_drop      = 3'd4
  } state_t;

  state_t      state;
  logic [4:0]  mdata_pending;
  logic [15:0] pyld_len_reg;
  logic        eob_reg;
  logic        eov_reg;

  logic [2:0]  hdr_pkt_type;
  logic [4:0]  hdr_num_mdata;
  logic [15:0] hdr_length;
  logic        hdr_is_data;
  logic        hdr_has_time;
  logic [5:0]  hdr_words;
  logic [15:0] hdr_pyld_len;
  logic        chdr_xfer;
  logic        last_mdata_line;
  logic [1:0]  last_keep;

  // --------------------
  // Header decode
  // --------------------
  assign hdr_pkt_type  = i_chdr.data[chdr_deframer_pkg::hdr_pkt_type_msb:
                                     chdr_deframer_pkg::hdr_pkt_type_lsb];
  assign hdr_num_mdata = i_chdr.data[chdr_deframer_pkg::hdr_num_mdata_msb:
                                     chdr_deframer_pkg::hdr_num_mdata_lsb];
  assign hdr_length    = i_chdr.data[chdr_deframer_pkg::hdr_length_msb:
                                     chdr_deframer_pkg::hdr_length_lsb];
  assign hdr_has_time  = (hdr_pkt_type == chdr_deframer_pkg::pkt_type_data_ts);
  assign hdr_is_data   = hdr_has_time || (hdr_pkt_type == chdr_deframer_pkg::pkt_type_data);
  // Header, optional timestamp and metadata words ahead of the payload
  assign hdr_words     = {1'b0, hdr_num_mdata} + 6'd1 + {5'd0, hdr_has_time};
  assign hdr_pyld_len  = hdr_length - {7'd0, hdr_words, 3'd0};

  assign chdr_xfer = i_chdr_valid && o_chdr_ready;

  // Input ready and end of metadata packet, both follow the state
  always_comb begin
    case (state)
      st_header: begin
        o_chdr_ready    = i_info_ready && i_mdata_ready;
        last_mdata_line = (hdr_num_mdata == 5'd0);
      end
      st_timestamp: begin
        o_chdr_ready    = i_info_ready && i_mdata_ready;
        last_mdata_line = 1'b0;
      end
      st_mdata: begin
        o_chdr_ready    = i_mdata_ready;
        last_mdata_line = (mdata_pending == 5'd1);
      end
      st_body: begin
        o_chdr_ready    = i_pyld_ready;
        last_mdata_line = 1'b0;
      end
      st_drop: begin
        o_chdr_ready    = 1'b1;
        last_mdata_line = 1'b0;
      end
      default: begin
        o_chdr_ready    = 1'b0;
        last_mdata_line = 1'b0;
      end
    endcase
  end

  // --------------------
  // State machine
  // --------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      state         <= st_header;
      mdata_pending <= 5'd0;
    end else if (chdr_xfer) begin
      case (state)
        st_header: begin
          mdata_pending <= hdr_num_mdata;
          // A packet ending at its header is simply skipped
          if (i_chdr.last) state <= st_header;
          else if (!hdr_is_data) state <= st_drop;
          else if (hdr_has_time) state <= st_timestamp;
          else if (hdr_num_mdata != 5'd0) state <= st_mdata;
          else state <= st_body;
        end
        st_timestamp: begin
          if (i_chdr.last) state <= st_header;
          else if (mdata_pending != 5'd0) state <= st_mdata;
          else state <= st_body;
        end
        st_mdata: begin
          // Count down and leave at 1
          if (i_chdr.last) state <= st_header;
          else if (mdata_pending == 5'd1) state <= st_body;
          else mdata_pending <= mdata_pending - 5'd1;
        end
        st_body, st_drop: begin
          if (i_chdr.last) state <= st_header;
        end
        default: state <= st_header;
      endcase
    end
  end

  // Flags and payload length captured at the header for the timestamp beat and keep
  always_ff @(posedge axis_chdr_clk) begin
    if (chdr_xfer && state == st_header) begin
      pyld_len_reg <= hdr_pyld_len;
      eob_reg      <= i_chdr.data[chdr_deframer_pkg::hdr_eob_bit];
      eov_reg      <= i_chdr.data[chdr_deframer_pkg::hdr_eov_bit];
    end
  end

  // --------------------
  // Stream outputs
  // --------------------
  // DATA packets get info at the header, DATA_TS packets at the timestamp word
  always_comb begin
    if (state == st_timestamp) begin
      o_info = '{timestamp: i_chdr.data, has_time: 1'b1, length: pyld_len_reg,
                 eob: eob_reg, eov: eov_reg};
    end else begin
      o_info = '{timestamp: '0, has_time: 1'b0, length: hdr_pyld_len,
                 eob: i_chdr.data[chdr_deframer_pkg::hdr_eob_bit],
                 eov: i_chdr.data[chdr_deframer_pkg::hdr_eov_bit]};
    end
  end
  assign o_info_valid = chdr_xfer && (state == st_timestamp ||
                        (state == st_header && hdr_pkt_type == chdr_deframer_pkg::pkt_type_data));

  // Metadata words, or one empty beat at the header when there are none
  assign o_mdata       = '{data: i_chdr.data, keep: (state == st_mdata),
                           last: i_chdr.last || last_mdata_line};
  assign o_mdata_valid = chdr_xfer && (state == st_mdata ||
                         (state == st_header && hdr_is_data && hdr_num_mdata == 5'd0));

  // Upper item unused when 1 to 4 bytes remain in the last word
  assign last_keep    = (pyld_len_reg[2:0] != 3'd0 && pyld_len_reg[2:0] <= 3'd4) ? 2'b01 : 2'b11;
  assign o_pyld       = '{data: i_chdr.data, keep: i_chdr.last ? last_keep : 2'b11,
                          last: i_chdr.last};
  assign o_pyld_valid = chdr_xfer && (state == st_body);

  a_legal_state : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    state inside {st_header, st_timestamp, st_mdata, st_body, st_drop});

endmodule

// File: design/chdr_pkt_pairing.sv
`timescale 1ns/1ps
// Output ordering stage of the CHDR deframer
// Counts finished metadata and payload packets so that each metadata packet
// leaves before its payload. With prefetch one more metadata packet may run ahead.
// Info is read from the head of its FIFO and popped with the last payload beat
module chdr_pkt_pairing #(
  parameter bit mdata_prefetch_en = 1'b1
) (
  input  logic                           axis_chdr_clk,
  input  logic                           axis_chdr_rst,
  // From the FIFOs
  input  chdr_deframer_pkg::mdata_beat_t i_mdata,
  input  logic                           i_mdata_valid,
  output logic                           o_mdata_ready,
  input  chdr_deframer_pkg::pyld_beat_t  i_pyld,
  input  logic                           i_pyld_valid,
  output logic                           o_pyld_ready,
  input  chdr_deframer_pkg::pkt_info_t   i_info,
  output logic                           o_info_ready,
  // External outputs
  output chdr_deframer_pkg::mdata_beat_t o_mdata,
  output logic                           o_mdata_valid,
  input  logic                           i_mdata_ready,
  output chdr_deframer_pkg::pyld_beat_t  o_pyld,
  output chdr_deframer_pkg::pkt_info_t   o_pyld_info,
  output logic                           o_pyld_valid,
  input  logic                           i_pyld_ready
);
  // Metadata packets allowed ahead of payload
  localparam logic [2:0] max_ahead = mdata_prefetch_en ? 3'd2 : 3'd1;

  logic [2:0] mdata_pkt_cnt;
  logic [2:0] pyld_pkt_cnt;
  logic [2:0] pkt_diff;
  logic       pass_mdata;
  logic       pass_pyld;

  // Wraps cleanly since the difference stays small
  assign pkt_diff   = mdata_pkt_cnt - pyld_pkt_cnt;
  assign pass_pyld  = (pkt_diff != 3'd0);
  assign pass_mdata = (pkt_diff < max_ahead);

  // --------------------
  // Packet counters
  // --------------------
  always_ff @(posedge axis_chdr_clk) begin
    if (axis_chdr_rst) begin
      mdata_pkt_cnt <= 3'd0;
      pyld_pkt_cnt  <= 3'd0;
    end else begin
      if (o_mdata_valid && i_mdata_ready && i_mdata.last) mdata_pkt_cnt <= mdata_pkt_cnt + 3'd1;
      if (o_pyld_valid && i_pyld_ready && i_pyld.last) pyld_pkt_cnt <= pyld_pkt_cnt + 3'd1;
    end
  end

  // Gated handshakes
  assign o_mdata       = i_mdata;
  assign o_mdata_valid = i_mdata_valid && pass_mdata;
  assign o_mdata_ready = i_mdata_ready && pass_mdata;

  assign o_pyld        = i_pyld;
  assign o_pyld_info   = i_info;
  assign o_pyld_valid  = i_pyld_valid && pass_pyld;
  assign o_pyld_ready  = i_pyld_ready && pass_pyld;
  // One info pop per payload packet
  assign o_info_ready  = o_pyld_ready && i_pyld_valid && i_pyld.last;

  a_prefetch_limit : assert property (@(posedge axis_chdr_clk) disable iff (axis_chdr_rst)
    pkt_diff <= max_ahead);

endmodule

// File: design/chdr_deframer.sv
`timescale 1ns/1ps
// Top level of the single-clock CHDR data packet deframer
// CHDR in, payload with per-packet sideband out, metadata out.
// Parser feeds info, metadata and payload FIFOs, the pairing stage orders the outputs
module chdr_deframer #(
  parameter bit mdata_prefetch_en = 1'b1
) (
  input  logic                           axis_chdr_clk,
  input  logic                           axis_chdr_rst,
  // CHDR input
  input  chdr_deframer_pkg::chdr_beat_t  i_chdr,
  input  logic                           i_chdr_valid,
  output logic                           o_chdr_ready,
  // Payload output with sideband
  output chdr_deframer_pkg::pyld_beat_t  o_pyld,
  output chdr_deframer_pkg::pkt_info_t   o_pyld_info,
  output logic                           o_pyld_valid,
  input  logic                           i_pyld_ready,
  // Metadata output
  output chdr_deframer_pkg::mdata_beat_t o_mdata,
  output logic                           o_mdata_valid,
  input  logic                           i_mdata_ready
);
  // Parser to FIFOs
  chdr_deframer_pkg::pkt_info_t   in_info;
  logic                           in_info_valid, in_info_ready;
  chdr_deframer_pkg::mdata_beat_t in_mdata;
  logic                           in_mdata_valid, in_mdata_ready;
  chdr_deframer_pkg::pyld_beat_t  in_pyld;
  logic                           in_pyld_valid, in_pyld_ready;

  // FIFOs to pairing stage
  chdr_deframer_pkg::pkt_info_t   fifo_info;
  logic                           fifo_info_ready;
  chdr_deframer_pkg::mdata_beat_t fifo_mdata;
  logic                           fifo_mdata_valid, fifo_mdata_ready;
  chdr_deframer_pkg::pyld_beat_t  fifo_pyld;
  logic                           fifo_pyld_valid, fifo_pyld_ready;

  chdr_header_parser parser0 (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_chdr, .i_chdr_valid, .o_chdr_ready,
    .o_info(in_info), .o_info_valid(in_info_valid), .i_info_ready(in_info_ready),
    .o_mdata(in_mdata), .o_mdata_valid(in_mdata_valid), .i_mdata_ready(in_mdata_ready),
    .o_pyld(in_pyld), .o_pyld_valid(in_pyld_valid), .i_pyld_ready(in_pyld_ready)
  );

  // Info is always ahead of its payload, so its valid is not needed downstream
  chdr_stream_fifo #(.payload_t(chdr_deframer_pkg::pkt_info_t)) info_fifo (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_data(in_info), .i_valid(in_info_valid), .o_ready(in_info_ready),
    .o_data(fifo_info), .o_valid(), .i_ready(fifo_info_ready)
  );

  chdr_stream_fifo #(.payload_t(chdr_deframer_pkg::mdata_beat_t)) mdata_fifo (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_data(in_mdata), .i_valid(in_mdata_valid), .o_ready(in_mdata_ready),
    .o_data(fifo_mdata), .o_valid(fifo_mdata_valid), .i_ready(fifo_mdata_ready)
  );

  chdr_stream_fifo #(.payload_t(chdr_deframer_pkg::pyld_beat_t)) pyld_fifo (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_data(in_pyld), .i_valid(in_pyld_valid), .o_ready(in_pyld_ready),
    .o_data(fifo_pyld), .o_valid(fifo_pyld_valid), .i_ready(fifo_pyld_ready)
  );

  chdr_pkt_pairing #(.mdata_prefetch_en(mdata_prefetch_en)) pairing0 (
    .axis_chdr_clk, .axis_chdr_rst,
    .i_mdata(fifo_mdata), .i_mdata_valid(fifo_mdata_valid), .o_mdata_ready(fifo_mdata_ready),
    .i_pyld(fifo_pyld), .i_pyld_valid(fifo_pyld_valid), .o_pyld_ready(fifo_pyld_ready),
    .i_info(fifo_info), .o_info_ready(fifo_info_ready),
    .o_mdata, .o_mdata_valid, .i_mdata_ready,
    .o_pyld, .o_pyld_info, .o_pyld_valid, .i_pyld_ready
  );

endmodule

// File: verification/tb_deframer_cases.svh
// Packet test cases for the CHDR deframer testbench, included inside the testbench module
// Columns: name, packet type, eob, eov, timestamp, metadata words,
// payload bytes, stall flag (random input gaps and output back-pressure)
`ifndef TB_DEFRAMER_CASES_SVH
`define TB_DEFRAMER_CASES_SVH

typedef struct {
  string       name;
  logic [2:0]  pkt_type;
  logic        eob;
  logic        eov;
  logic [63:0] timestamp;
  int          num_mdata;
  int          pyld_bytes;
  logic        stall;
} pkt_case_t;

localparam int n_cases = 12;

pkt_case_t cases [n_cases] = '{
  '{"data_no_mdata",  3'd6, 1'b0, 1'b0, 64'h0,                  0, 16, 1'b0},
  '{"data_ts_mdata3", 3'd7, 1'b0, 1'b0, 64'h0000_0123_4567_89ab, 3, 24, 1'b0},
  '{"drop_type0",     3'd0, 1'b0, 1'b0, 64'h0,                  0, 16, 1'b0},
  '{"after_drop",     3'd6, 1'b0, 1'b1, 64'h0,                  1, 20, 1'b0},
  '{"keep_12_bytes",  3'd7, 1'b0, 1'b0, 64'h0000_0000_dead_0001, 0, 12, 1'b0},
  '{"keep_16_bytes",  3'd6, 1'b0, 1'b0, 64'h0,                  2, 16, 1'b0},
  '{"eob_eov_ts",     3'd7, 1'b1, 1'b1, 64'h1111_2222_3333_4444, 1, 40, 1'b1},
  '{"stall_eob",      3'd6, 1'b1, 1'b0, 64'h0,                  4, 32, 1'b1},
  '{"stall_eov_ts",   3'd7, 1'b0, 1'b1, 64'h0000_0000_0000_0abc, 0,  8, 1'b1},
  '{"drop_type2",     3'd2, 1'b1, 1'b1, 64'h0,                  0, 24, 1'b1},
  '{"stall_short",    3'd6, 1'b0, 1'b0, 64'h0,                  2,  4, 1'b1},
  '{"stall_ts_md5",   3'd7, 1'b1, 1'b0, 64'hfedc_ba98_7654_3210, 5, 44, 1'b1}
};

`endif

// File: verification/tb_chdr_deframer.sv
`timescale 1ns/1ps
// Testbench for the CHDR deframer with metadata prefetch enabled
// Builds one CHDR packet per table row, queues the expected metadata, payload
// and info, then checks both output streams and their packet ordering
module tb_chdr_deframer;
  logic                           axis_chdr_clk;
  logic                           axis_chdr_rst;
  chdr_deframer_pkg::chdr_beat_t  i_chdr;
  logic                           i_chdr_valid;
  logic                           o_chdr_ready;
  chdr_deframer_pkg::pyld_beat_t  o_pyld;
  chdr_deframer_pkg::pkt_info_t   o_pyld_info;
  logic                           o_pyld_valid;
  logic                           i_pyld_ready;
  chdr_deframer_pkg::mdata_beat_t o_mdata;
  logic                           o_mdata_valid;
  logic                           i_mdata_ready;

  int   seed = 32'h3bb52ad2;
  logic stall_mode = 1'b0;
  int   error_count = 0;
  int   timeout_limit = 0;
  int   mdata_pkts_done = 0;
  int   pyld_pkts_done = 0;

  // Expected beats with the row name of each
  chdr_deframer_pkg::pyld_beat_t  pyld_q [$];
  chdr_deframer_pkg::mdata_beat_t mdata_q [$];
  chdr_deframer_pkg::pkt_info_t   info_q [$];
  string                          pyld_name_q [$];
  string                          mdata_name_q [$];

  `include "tb_deframer_cases.svh"

  chdr_deframer #(.mdata_prefetch_en(1'b1)) dut0 (.*);

  initial begin
    axis_chdr_clk = 1'b0;
    forever #5 axis_chdr_clk = ~axis_chdr_clk;
  end

  // --------------------
  // Checks
  // --------------------
  task automatic stop_with_error(input string line);
    error_count++;
    $display("%s", line);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic compare_pyld(input string name, input chdr_deframer_pkg::pyld_beat_t exp_b,
                              input chdr_deframer_pkg::pyld_beat_t act_b);
    if (exp_b !== act_b)
      stop_with_error($sformatf("[FAIL] %s: payload beat expected %h, actual %h",
                                name, exp_b, act_b));
  endtask

  // Data of the empty beat carries no meaning
  task automatic compare_mdata(input string name, input chdr_deframer_pkg::mdata_beat_t exp_b,
                               input chdr_deframer_pkg::mdata_beat_t act_b);
    if (exp_b.keep !== act_b.keep || exp_b.last !== act_b.last ||
        (exp_b.keep && exp_b.data !== act_b.data))
      stop_with_error($sformatf("[FAIL] %s: metadata beat expected %h, actual %h",
                                name, exp_b, act_b));
  endtask

  // Timestamp only counts when has_time is set
  task automatic compare_info(input string name, input chdr_deframer_pkg::pkt_info_t exp_i,
                              input chdr_deframer_pkg::pkt_info_t act_i);
    if (exp_i.has_time !== act_i.has_time || exp_i.length !== act_i.length ||
        exp_i.eob !== act_i.eob || exp_i.eov !== act_i.eov ||
        (exp_i.has_time && exp_i.timestamp !== act_i.timestamp))
      stop_with_error($sformatf("[FAIL] %s: payload info expected %h, actual %h",
                                name, exp_i, act_i));
  endtask

  // --------------------
  // Stimulus
  // --------------------
  function automatic int packet_words(input int idx);
    int has_time;
    has_time = (cases[idx].pkt_type == chdr_deframer_pkg::pkt_type_data_ts) ? 1 : 0;
    return 1 + has_time + cases[idx].num_mdata + (cases[idx].pyld_bytes + 7) / 8;
  endfunction

  // Transfer happens at the rising edge after ready is seen at the falling edge
  task automatic send_beat(input logic [63:0] data, input logic last);
    i_chdr       = '{data: data, last: last};
    i_chdr_valid = 1'b1;
    @(negedge axis_chdr_clk);
    while (!o_chdr_ready) @(negedge axis_chdr_clk);
    @(posedge axis_chdr_clk);
    #1;
    i_chdr_valid = 1'b0;
  endtask

  task automatic send_packet(input int idx);
    logic [63:0]                  words [$];
    logic [63:0]                  hdr;
    logic [63:0]                  word;
    logic [31:0]                  r;
    logic [1:0]                   tail_keep;
    bit                           has_time;
    bit                           is_data;
    int                           n_pyld;
    int                           length;
    chdr_deframer_pkg::pkt_info_t info;
    has_time = (cases[idx].pkt_type == chdr_deframer_pkg::pkt_type_data_ts);
    is_data  = has_time || (cases[idx].pkt_type == chdr_deframer_pkg::pkt_type_data);
    n_pyld   = (cases[idx].pyld_bytes + 7) / 8;
    length   = cases[idx].pyld_bytes + 8 * (1 + has_time + cases[idx].num_mdata);
    // Keep 01 when 1 to 4 bytes remain in the last word
    tail_keep = (cases[idx].pyld_bytes % 8 inside {[1:4]}) ? 2'b01 : 2'b11;
    hdr = '0;
    hdr[chdr_deframer_pkg::hdr_eob_bit] = cases[idx].eob;
    hdr[chdr_deframer_pkg::hdr_eov_bit] = cases[idx].eov;
    hdr[55:53] = cases[idx].pkt_type;
    hdr[52:48] = cases[idx].num_mdata[4:0];
    hdr[31:16] = length[15:0];
    hdr[15:0]  = idx[15:0];
    words.push_back(hdr);
    if (has_time) words.push_back(cases[idx].timestamp);
    for (int i = 0; i < cases[idx].num_mdata; i++) begin
      word = {$random(seed), $random(seed)};
      words.push_back(word);
      if (is_data) begin
        mdata_q.push_back('{data: word, keep: 1'b1, last: (i == cases[idx].num_mdata - 1)});
        mdata_name_q.push_back(cases[idx].name);
      end
    end
    if (is_data && cases[idx].num_mdata == 0) begin
      mdata_q.push_back('{data: '0, keep: 1'b0, last: 1'b1});
      mdata_name_q.push_back(cases[idx].name);
    end
    for (int i = 0; i < n_pyld; i++) begin
      word = {$random(seed), $random(seed)};
      words.push_back(word);
      if (is_data) begin
        pyld_q.push_back('{data: word, keep: (i == n_pyld - 1) ? tail_keep : 2'b11,
                           last: (i == n_pyld - 1)});
        pyld_name_q.push_back(cases[idx].name);
      end
    end
    if (is_data) begin
      info = '{timestamp: has_time ? cases[idx].timestamp : 64'h0, has_time: has_time,
               length: cases[idx].pyld_bytes[15:0], eob: cases[idx].eob, eov: cases[idx].eov};
      info_q.push_back(info);
    end
    stall_mode = cases[idx].stall;
    foreach (words[i]) begin
      // Random idle cycle ahead of a beat
      if (stall_mode) begin
        r = $random(seed);
        if (r[1:0] == 2'd0) begin
          @(posedge axis_chdr_clk);
          #1;
        end
      end
      send_beat(words[i], i == words.size() - 1);
    end
  endtask

  // Output back-pressure, ready high three cycles in four while stalling
  initial begin
    logic [31:0] r;
    i_pyld_ready  = 1'b1;
    i_mdata_ready = 1'b1;
    forever begin
      // Draw at the falling edge, apply just after the next rising edge
      @(negedge axis_chdr_clk);
      r = stall_mode ? $random(seed) : 32'hf;
      @(posedge axis_chdr_clk);
      #1;
      i_pyld_ready  = r[0] | r[1];
      i_mdata_ready = r[2] | r[3];
    end
  end

  // --------------------
  // Monitors
  // --------------------
  task automatic check_pyld_beat();
    if (pyld_q.size() == 0 || info_q.size() == 0)
      stop_with_error("Payload beat came out with none expected");
    if (mdata_pkts_done <= pyld_pkts_done)
      stop_with_error($sformatf("Payload of %s left before its metadata", pyld_name_q[0]));
    compare_pyld(pyld_name_q[0], pyld_q.pop_front(), o_pyld);
    compare_info(pyld_name_q[0], info_q[0], o_pyld_info);
    if (o_pyld.last) begin
      void'(info_q.pop_front());
      pyld_pkts_done++;
    end
    void'(pyld_name_q.pop_front());
  endtask

  task automatic check_mdata_beat();
    if (mdata_q.size() == 0)
      stop_with_error("Metadata beat came out with none expected");
    compare_mdata(mdata_name_q.pop_front(), mdata_q.pop_front(), o_mdata);
    if (o_mdata.last) mdata_pkts_done++;
  endtask

  // Payload is checked against the counts from before this cycle
  initial begin
    forever begin
      @(negedge axis_chdr_clk);
      if (o_pyld_valid && i_pyld_ready) check_pyld_beat();
      if (o_mdata_valid && i_mdata_ready) check_mdata_beat();
      if (mdata_pkts_done - pyld_pkts_done > 2)
        stop_with_error("Metadata ran more than two packets ahead of payload");
    end
  end

  // Watchdog
  initial begin
    int cycles;
    cycles = 0;
    wait (timeout_limit != 0);
    forever begin
      @(posedge axis_chdr_clk);
      cycles++;
      if (cycles >= timeout_limit)
        stop_with_error($sformatf("Timed out after %0d cycles with output still missing", cycles));
    end
  end

  // Main sequence
  initial begin
    int total_beats;
    i_chdr        = '0;
    i_chdr_valid  = 1'b0;
    axis_chdr_rst = 1'b1;
    total_beats   = 0;
    for (int i = 0; i < n_cases; i++) total_beats += packet_words(i);
    timeout_limit = 8 * total_beats + 200;
    repeat (3) @(posedge axis_chdr_clk);
    #1;
    axis_chdr_rst = 1'b0;
    for (int i = 0; i < n_cases; i++) send_packet(i);
    stall_mode = 1'b0;
    while (pyld_q.size() != 0 || mdata_q.size() != 0 || info_q.size() != 0)
      @(posedge axis_chdr_clk);
    // Catch any stray beats
    repeat (10) @(posedge axis_chdr_clk);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+verification
design/chdr_deframer_pkg.sv
design/chdr_stream_fifo.sv
design/chdr_header_parser.sv
design/chdr_pkt_pairing.sv
design/chdr_deframer.sv
verification/tb_chdr_deframer.sv
